//--- logic/uart_pkg.sv
package uart_pkg;

   // frame and command lengths in bit times
   localparam int FRAME_BITS = 11;
   localparam int CMD_BITS   = 2 * FRAME_BITS;

   // one serial frame, bit 0 leaves the line first
   typedef struct packed {
      logic       stop;
      logic       parity;
      logic [7:0] data;    // lsb first on the line
      logic       start;
   } uart_frame_t;

   typedef struct packed {
      logic [7:0] hi;
      logic [7:0] lo;      // sent first
   } cmd_bytes_t;

   // command word, seen whole at the port and byte-wise by the shifter
   typedef union packed {
      logic [15:0] word;
      cmd_bytes_t  bytes;
   } cmd_word_u;

   typedef struct packed {
      logic [7:0] data;
      logic       parity_err;
      logic       frame_err;
   } rx_result_t;

   // bit that makes the total count of ones odd
   function automatic logic odd_parity(input logic [7:0] data);
      return ~^data;
   endfunction

endpackage

//--- logic/bit_timer.sv
`timescale 1ns/1ps

module bit_timer #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic clk,
   input  logic rst_n,
   input  logic run,
   input  logic start,
   output logic bit_tick
);

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] FULL_RELOAD = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF_RELOAD = CW'(CLKS_PER_BIT / 2 - 1);

   logic [CW-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (start) begin
         cnt <= HALF_RELOAD;          // first tick lands mid-bit
      end else if (!run) begin
         cnt <= '0;
      end else if (cnt == '0) begin
         cnt <= FULL_RELOAD;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // users qualify the tick with their own state, so it is not gated by run here
   assign bit_tick = (cnt == '0);

endmodule

//--- logic/tx_sequencer.sv
`timescale 1ns/1ps

module tx_sequencer
   import uart_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic cmd_vld,
   input  logic bit_tick,
   output logic load,
   output logic shift,
   output logic tx_run,
   output logic cmd_rdy
);

   typedef enum logic {
      IDLE,
      SEND
   } state_t;

   state_t     state;
   logic [4:0] bit_idx;
   logic       last_tick;

   assign cmd_rdy = (state == IDLE);
   assign load    = cmd_rdy && cmd_vld;

   // end of the 22nd bit period
   assign last_tick = (state == SEND) && bit_tick && (bit_idx == 5'(CMD_BITS - 1));

   // timer runs from the accepting cycle; it drops in the last tick cycle so the
   // count is back at zero when cmd_rdy rises
   assign tx_run = load || ((state == SEND) && !last_tick);

   // the tick seen in the accepting cycle only restarts the timer
   assign shift = (state == SEND) && bit_tick;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= IDLE;
         bit_idx <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (load) begin
                  state   <= SEND;
                  bit_idx <= '0;
               end
            end
            SEND: begin
               if (bit_tick) begin
                  if (last_tick) begin
                     state   <= IDLE;
                     bit_idx <= '0;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

//--- logic/frame_shifter.sv
`timescale 1ns/1ps

module frame_shifter
   import uart_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  cmd_word_u cmd,
   input  logic      load,
   input  logic      shift,
   output logic      tx
);

   uart_frame_t         frame_lo;
   uart_frame_t         frame_hi;
   logic [CMD_BITS-1:0] sreg;
   logic [CMD_BITS-1:0] sreg_nxt;

   always_comb begin
      frame_lo.start  = 1'b0;
      frame_lo.data   = cmd.bytes.lo;
      frame_lo.parity = odd_parity(cmd.bytes.lo);
      frame_lo.stop   = 1'b1;

      frame_hi.start  = 1'b0;
      frame_hi.data   = cmd.bytes.hi;
      frame_hi.parity = odd_parity(cmd.bytes.hi);
      frame_hi.stop   = 1'b1;
   end

   always_comb begin
      if (load) begin
         sreg_nxt = {frame_hi, frame_lo};         // low frame in the bottom bits
      end else if (shift) begin
         sreg_nxt = {1'b1, sreg[CMD_BITS-1:1]};   // ones behind keep the line idle
      end else begin
         sreg_nxt = sreg;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sreg <= '1;
         tx   <= 1'b1;
      end else begin
         sreg <= sreg_nxt;
         tx   <= sreg_nxt[0];   // start bit shows right after the load edge
      end
   end

endmodule

//--- logic/rx_sampler.sv
`timescale 1ns/1ps

module rx_sampler
   import uart_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   input  logic       bit_tick,
   output logic       rx_start,
   output logic       rx_run,
   output logic       read_rdy,
   output rx_result_t result
);

   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA
   } state_t;

   state_t      state;
   logic        rx_meta;
   logic        rx_sync;
   logic        rx_prev;
   logic [3:0]  bit_cnt;
   logic        last_sample;
   uart_frame_t frame_q;
   uart_frame_t frame_nxt;

   // two-flop synchronizer plus one stage for the edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign rx_start = (state == IDLE) && rx_prev && !rx_sync;
   assign rx_run   = (state != IDLE);

   // samples enter at the top and walk down, so the start bit ends at bit 0
   assign frame_nxt = uart_frame_t'({rx_sync, frame_q[FRAME_BITS-1:1]});

   // ten samples after the start bit, the last one is the stop bit
   assign last_sample = (state == DATA) && bit_tick && (bit_cnt == 4'(FRAME_BITS - 2));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (rx_start) begin
                  state <= START;
               end
            end
            START: begin
               if (bit_tick) begin
                  if (!rx_sync) begin
                     state   <= DATA;
                     bit_cnt <= '0;
                  end else begin
                     state <= IDLE;     // high again at mid-bit, a glitch
                  end
               end
            end
            DATA: begin
               if (bit_tick) begin
                  if (last_sample) begin
                     state <= IDLE;
                  end
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (bit_tick && (state != IDLE)) begin
         frame_q <= frame_nxt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_rdy <= 1'b0;
         result   <= '0;
      end else begin
         read_rdy <= last_sample;
         if (last_sample) begin
            result.data       <= frame_nxt.data;
            result.parity_err <= (frame_nxt.parity != odd_parity(frame_nxt.data));
            result.frame_err  <= !frame_nxt.stop;
         end
      end
   end

endmodule

//--- logic/uart_link.sv
`timescale 1ns/1ps

module uart_link
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk,
   input  logic       rst_n,
   input  cmd_word_u  cmd_in,
   input  logic       cmd_vld,
   output logic       cmd_rdy,
   output logic       tx,
   input  logic       rx,
   output logic       read_rdy,
   output logic [7:0] read_data,
   output logic       parity_err,
   output logic       frame_err
);

   logic       load;
   logic       shift;
   logic       tx_run;
   logic       tx_tick;
   logic       rx_start;
   logic       rx_run;
   logic       rx_tick;
   rx_result_t rx_result;

   tx_sequencer tx_seq_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd_vld  (cmd_vld),
      .bit_tick (tx_tick),
      .load     (load),
      .shift    (shift),
      .tx_run   (tx_run),
      .cmd_rdy  (cmd_rdy)
   );

   bit_timer #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) tx_timer_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (tx_run),
      .start    (1'b0),       // transmit keeps whole periods
      .bit_tick (tx_tick)
   );

   frame_shifter shifter_i (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (cmd_in),
      .load  (load),
      .shift (shift),
      .tx    (tx)
   );

   rx_sampler rx_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rx       (rx),
      .bit_tick (rx_tick),
      .rx_start (rx_start),
      .rx_run   (rx_run),
      .read_rdy (read_rdy),
      .result   (rx_result)
   );

   bit_timer #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) rx_timer_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (rx_run),
      .start    (rx_start),
      .bit_tick (rx_tick)
   );

   assign read_data  = rx_result.data;
   assign parity_err = rx_result.parity_err;
   assign frame_err  = rx_result.frame_err;

endmodule

//--- tests/uart_link_tb.sv
`timescale 1ns/1ps

module uart_link_tb
   import uart_pkg::*;
;

   localparam int CLKS_PER_BIT = 4;
   localparam int FRAME_LEN    = 11;
   localparam int LINE_BITS    = 2 * FRAME_LEN;
   localparam int CMD_CLKS     = LINE_BITS * CLKS_PER_BIT;
   localparam int NUM_CMDS     = 20;
   localparam int NUM_FRAMES   = 20;
   localparam int MAX_CYCLES   = 12000;   // all tests together take about 3500 cycles

   typedef struct packed {
      logic [7:0] data;
      logic       parity_err;
      logic       frame_err;
   } rx_capture_t;

   logic        clk;
   logic        rst_n;
   cmd_word_u   cmd_in;
   logic        cmd_vld;
   logic        cmd_rdy;
   logic        tx;
   logic        rx;
   logic        read_rdy;
   logic [7:0]  read_data;
   logic        parity_err;
   logic        frame_err;

   logic        rx_line;     // serializer output before the loopback mux
   logic        loopback;
   logic        rdy_prev;
   integer      seed;
   int          err_cnt;
   int          err_at_start;
   int          test_cnt;
   int          bad_tests;
   int          tx_done;
   int          cycle_cnt;
   int          mon_n;
   logic [21:0] mon_line;
   rx_capture_t rx_caps[$];

   uart_link #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_in     (cmd_in),
      .cmd_vld    (cmd_vld),
      .cmd_rdy    (cmd_rdy),
      .tx         (tx),
      .rx         (rx),
      .read_rdy   (read_rdy),
      .read_data  (read_data),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // parity bit that makes the ones in byte plus bit an odd count
   function automatic logic byte_parity(input logic [7:0] b);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         if (b[i])
            ones++;
      end
      return (ones % 2 == 0);
   endfunction

   function automatic logic [10:0] frame_bits(input logic [7:0] b);
      logic [10:0] f;
      f[0]   = 1'b0;            // start
      f[8:1] = b;               // lsb first
      f[9]   = byte_parity(b);
      f[10]  = 1'b1;            // stop
      return f;
   endfunction

   // whole line sequence of one command with bit 0 going out first
   function automatic logic [21:0] expected_line(input logic [15:0] value);
      return {frame_bits(value[15:8]), frame_bits(value[7:0])};
   endfunction

   task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
      err_cnt++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
   endtask

   task automatic fault(input string what);
      err_cnt++;
      $display("error at %0t: %s", $time, what);
   endtask

   task automatic start_test();
      err_at_start = err_cnt;
   endtask

   task automatic close_test(input string name);
      test_cnt++;
      if (err_cnt == err_at_start) begin
         $display("test %s: ok", name);
      end else begin
         bad_tests++;
         $display("test %s: %0d errors", name, err_cnt - err_at_start);
      end
   endtask

   task automatic issue_command(input logic [15:0] value);
      @(posedge clk);
      cmd_in.word <= value;
      cmd_vld     <= 1'b1;
      @(posedge clk);       // accepting edge while cmd_rdy is high
      cmd_vld     <= 1'b0;
   endtask

   task automatic await_tx(input int target);
      while (tx_done < target)
         @(negedge clk);
   endtask

   task automatic collect_rx(input int count);
      while (rx_caps.size() < count)
         @(negedge clk);
   endtask

   task automatic hold_idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         rx_line <= 1'b1;
      end
   endtask

   // one frame on rx; returns after the stop bit has been held its full time
   task automatic serialize_byte(input logic [7:0] b, input logic flip_parity,
                                 input logic stop_bit);
      logic [10:0] bits;
      bits     = frame_bits(b);
      bits[9]  = bits[9] ^ flip_parity;
      bits[10] = stop_bit;
      for (int i = 0; i < FRAME_LEN; i++) begin
         @(posedge clk);
         rx_line <= bits[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
   endtask

   always @(posedge clk) begin
      rx <= loopback ? tx : rx_line;
   end

   // tx monitor following each accepted command through its 88 cycles
   initial begin
      forever begin
         @(negedge clk);
         if (cmd_vld && cmd_rdy) begin
            mon_line = expected_line(cmd_in.word);
            @(posedge clk);
            for (mon_n = 0; mon_n <= CMD_CLKS; mon_n++) begin
               @(negedge clk);
               if (mon_n < CMD_CLKS) begin
                  if (cmd_rdy !== 1'b0)
                     mismatch("cmd_rdy", cmd_rdy, 1'b0);
                  if (mon_n % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                     if (tx !== mon_line[mon_n / CLKS_PER_BIT])
                        mismatch("tx", tx, mon_line[mon_n / CLKS_PER_BIT]);
                  end
               end else begin
                  if (cmd_rdy !== 1'b1)
                     mismatch("cmd_rdy", cmd_rdy, 1'b1);
                  if (tx !== 1'b1)
                     mismatch("tx", tx, 1'b1);
               end
            end
            tx_done++;
         end
      end
   end

   always @(negedge clk) begin
      if (read_rdy) begin
         rx_caps.push_back({read_data, parity_err, frame_err});
         if (rdy_prev)
            fault("read_rdy stayed high for more than one cycle");
      end
      rdy_prev = read_rdy;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
   end

   task automatic check_reset_state();
      start_test();
      if (tx !== 1'b1)
         mismatch("tx", tx, 1'b1);
      if (cmd_rdy !== 1'b1)
         mismatch("cmd_rdy", cmd_rdy, 1'b1);
      if (read_rdy !== 1'b0)
         mismatch("read_rdy", read_rdy, 1'b0);
      if (read_data !== 8'h00)
         mismatch("read_data", read_data, 8'h00);
      if (parity_err !== 1'b0 || frame_err !== 1'b0)
         mismatch("error flags", {parity_err, frame_err}, 2'b00);
      close_test("after_reset");
   endtask

   task automatic transmit_random_commands();
      logic [31:0] rnd;
      int          base;
      start_test();
      base = tx_done;
      for (int i = 0; i < NUM_CMDS; i++) begin
         rnd = $random(seed);
         issue_command(rnd[15:0]);
         await_tx(base + i + 1);
      end
      close_test("tx_random");
   endtask

   task automatic ignore_busy_command();
      logic [31:0] rnd;
      int          base;
      logic        idle_ok;
      start_test();
      base = tx_done;
      rnd  = $random(seed);
      issue_command(rnd[15:0]);
      repeat (20) @(posedge clk);
      cmd_in.word <= ~rnd[15:0];     // different word while busy
      cmd_vld     <= 1'b1;
      @(posedge clk);
      cmd_vld     <= 1'b0;
      await_tx(base + 1);
      idle_ok = 1'b1;
      for (int n = 0; n < 2 * CMD_CLKS && idle_ok; n++) begin
         @(negedge clk);
         if (tx !== 1'b1) begin
            mismatch("tx", tx, 1'b1);
            idle_ok = 1'b0;
         end
      end
      close_test("busy_ignore");
   endtask

   task automatic receive_random_bytes();
      logic [31:0] rnd;
      logic [7:0]  sent[NUM_FRAMES];
      int          gap;
      start_test();
      rx_caps.delete();
      for (int i = 0; i < NUM_FRAMES; i++) begin
         rnd     = $random(seed);
         sent[i] = rnd[7:0];
         gap     = int'(rnd[10:8]);
         if (i == 1 || i == 2)
            gap = 0;                  // back to back
         hold_idle(gap);
         serialize_byte(sent[i], 1'b0, 1'b1);
      end
      hold_idle(4);
      collect_rx(NUM_FRAMES);
      repeat (60) @(negedge clk);
      if (rx_caps.size() != NUM_FRAMES)
         mismatch("read_rdy pulses", rx_caps.size(), NUM_FRAMES);
      for (int i = 0; i < NUM_FRAMES && i < rx_caps.size(); i++) begin
         if (rx_caps[i].data !== sent[i])
            mismatch("read_data", rx_caps[i].data, sent[i]);
         if (rx_caps[i].parity_err !== 1'b0)
            mismatch("parity_err", rx_caps[i].parity_err, 1'b0);
         if (rx_caps[i].frame_err !== 1'b0)
            mismatch("frame_err", rx_caps[i].frame_err, 1'b0);
      end
      close_test("rx_random");
   endtask

   task automatic loop_tx_to_rx();
      logic [31:0] rnd;
      int          base;
      logic [3:0]  flags;
      start_test();
      rx_caps.delete();
      rnd  = $random(seed);
      base = tx_done;
      @(posedge clk);
      loopback <= 1'b1;
      issue_command(rnd[15:0]);
      await_tx(base + 1);
      collect_rx(2);
      repeat (20) @(negedge clk);
      @(posedge clk);
      loopback <= 1'b0;
      if (rx_caps.size() != 2) begin
         mismatch("read_rdy pulses", rx_caps.size(), 2);
      end else begin
         if (rx_caps[0].data !== rnd[7:0])
            mismatch("read_data low byte", rx_caps[0].data, rnd[7:0]);
         if (rx_caps[1].data !== rnd[15:8])
            mismatch("read_data high byte", rx_caps[1].data, rnd[15:8]);
         flags = {rx_caps[0].parity_err, rx_caps[0].frame_err,
                  rx_caps[1].parity_err, rx_caps[1].frame_err};
         if (flags !== 4'b0000)
            mismatch("error flags", flags, 4'b0000);
      end
      close_test("loopback");
   endtask

   task automatic receive_bad_frame(input string name, input logic flip_parity,
                                    input logic stop_bit);
      logic [31:0] rnd;
      start_test();
      rx_caps.delete();
      rnd = $random(seed);
      serialize_byte(rnd[7:0], flip_parity, stop_bit);
      hold_idle(8);
      collect_rx(1);
      repeat (20) @(negedge clk);
      if (rx_caps.size() != 1) begin
         mismatch("read_rdy pulses", rx_caps.size(), 1);
      end else begin
         if (rx_caps[0].data !== rnd[7:0])
            mismatch("read_data", rx_caps[0].data, rnd[7:0]);
         if (rx_caps[0].parity_err !== flip_parity)
            mismatch("parity_err", rx_caps[0].parity_err, flip_parity);
         if (rx_caps[0].frame_err !== !stop_bit)
            mismatch("frame_err", rx_caps[0].frame_err, !stop_bit);
      end
      close_test(name);
   endtask

   task automatic reject_glitch();
      start_test();
      rx_caps.delete();
      @(posedge clk);
      rx_line <= 1'b0;
      @(posedge clk);
      rx_line <= 1'b1;                // one clock low on an idle line
      repeat (60) @(negedge clk);
      if (rx_caps.size() != 0)
         mismatch("read_rdy pulses", rx_caps.size(), 0);
      serialize_byte(8'h5a, 1'b0, 1'b1);   // receiver still takes a good frame
      hold_idle(4);
      collect_rx(1);
      repeat (20) @(negedge clk);
      if (rx_caps.size() != 1)
         mismatch("read_rdy pulses", rx_caps.size(), 1);
      else if (rx_caps[0].data !== 8'h5a)
         mismatch("read_data", rx_caps[0].data, 8'h5a);
      close_test("glitch");
   endtask

   initial begin
      seed         = 32'ha69aafc1;
      rst_n        = 1'b0;
      cmd_in       = '0;
      cmd_vld      = 1'b0;
      rx           = 1'b1;
      rx_line      = 1'b1;
      loopback     = 1'b0;
      rdy_prev     = 1'b0;
      err_cnt      = 0;
      err_at_start = 0;
      test_cnt     = 0;
      bad_tests    = 0;
      tx_done      = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      check_reset_state();
      transmit_random_commands();
      ignore_busy_command();
      receive_random_bytes();
      loop_tx_to_rx();
      receive_bad_frame("bad_parity", 1'b1, 1'b1);
      receive_bad_frame("bad_stop", 1'b0, 1'b0);
      reject_glitch();

      $display("summary: %0d tests, %0d with errors, %0d errors in total",
               test_cnt, bad_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- flist.f
logic/uart_pkg.sv
logic/bit_timer.sv
logic/tx_sequencer.sv
logic/frame_shifter.sv
logic/rx_sampler.sv
logic/uart_link.sv
tests/uart_link_tb.sv

//--- run.sh
#!/bin/sh
# build and run the uart_link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module uart_link_tb \
   -f flist.f \
   -o uart_link_sim

./obj_dir/uart_link_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
if ! grep -q "All checks passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
